/* tb.f */
common/video_pkg.sv
video/video_timing_gen.sv
video/test_pattern_gen.sv
verilog/hdmi_pattern_top.sv
sim/tb_hdmi_pattern.sv

/* Makefile */
# Verilator build and run of the hdmi pattern testbench

TOP  := tb_hdmi_pattern
SRCS := $(filter %.sv,$(shell cat tb.f))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/V$(TOP): tb.f $(SRCS)
	verilator --binary --top-module $(TOP) -Mdir obj_dir -f tb.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

/* sim/tb_hdmi_pattern.sv */
//--------------------------------------------------------------------------
// testbench for the hdmi pattern source on a small raster, with a
// raster model that predicts enable, syncs and pixel data per cycle
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module tb_hdmi_pattern import video_pkg::*; ();

  // small raster so that a frame is only 240 cycles
  localparam int h_active = 16;
  localparam int h_total  = 24;
  localparam int hs_start = 18;
  localparam int hs_end   = 21;
  localparam int v_active = 6;
  localparam int v_total  = 10;
  localparam int vs_start = 7;
  localparam int vs_end   = 8;
  localparam int box_lo   = 4;
  localparam int box_hi   = 8;

  localparam int frame_cycles    = h_total * v_total;
  localparam int settle_cycles   = 4;  // mode sampling plus pipeline
  localparam int watchdog_cycles = 20 * frame_cycles;

  logic      sys0_clk;
  logic      rst;
  mode_t     mode_sw;
  logic      hdmi_de;
  logic      hdmi_hs;
  logic      hdmi_vs;
  pix_data_t hdmi_data;

  int     errors;
  int     cyc;      // cycles since reset release
  logic   pos_vld;  // outputs carry a raster position
  int     mx;       // model position at the outputs
  int     my;
  int     mf;
  integer seed;

  hdmi_pattern_top #(
    .h_active (h_active),
    .h_total  (h_total),
    .hs_start (hs_start),
    .hs_end   (hs_end),
    .v_active (v_active),
    .v_total  (v_total),
    .vs_start (vs_start),
    .vs_end   (vs_end),
    .box_lo   (box_lo),
    .box_hi   (box_hi)
  ) hdmi_pattern_top_inst (
    .sys0_clk  (sys0_clk),
    .rst       (rst),
    .mode_sw   (mode_sw),
    .hdmi_de   (hdmi_de),
    .hdmi_hs   (hdmi_hs),
    .hdmi_vs   (hdmi_vs),
    .hdmi_data (hdmi_data)
  );

  initial begin
    sys0_clk = 1'b0;
    forever #2 sys0_clk = ~sys0_clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge sys0_clk);
    $display("watchdog: tests did not finish within %0d clock cycles", watchdog_cycles);
    $display(">>> FAIL");
    $finish;
  end

  // luma from the pattern table with the upper byte fixed
  function automatic pix_data_t expected_pix(input mode_t m, input int x, input int y,
                                             input int f);
    logic       in_box;
    int         ramp;
    int         sh;
    int         shifted;
    logic [7:0] luma;
    in_box = (x >= box_lo) && (x <= box_hi) && (y >= box_lo) && (y <= box_hi);
    ramp   = x;
    sh     = 0;
    if (m <= 4'd7) begin
      ramp = m[0] ? y : x;  // odd modes follow the line
      sh   = int'(m[2:1]);
    end else if (m == 4'd8 && in_box) begin
      ramp = y;
    end else if (m == 4'd9 && in_box) begin
      ramp = f;
    end
    shifted = ramp >> sh;
    luma    = shifted[7:0];
    return {chroma_mid, luma};
  endfunction

  task automatic check_bit(input string name, input string what, input logic exp,
                           input logic act);
    if (act !== exp) begin
      errors = errors + 1;
      $display("** Error [%s] %s at (%0d,%0d) frame %0d: expected %0b, actual %0b",
               name, what, mx, my, mf, exp, act);
    end
  endtask

  task automatic check_pix(input string name, input pix_data_t exp, input pix_data_t act);
    if (act !== exp) begin
      errors = errors + 1;
      $display("** Error [%s] data at (%0d,%0d) frame %0d: expected %h, actual %h",
               name, mx, my, mf, exp, act);
    end
  endtask

  // steps one falling edge and moves the model by the counter rules
  task automatic advance();
    @(negedge sys0_clk);
    cyc = cyc + 1;
    if (cyc == 2) begin
      pos_vld = 1'b1;  // position 0 reaches the pins
    end else if (cyc > 2) begin
      mx = mx + 1;
      if (mx == h_total) begin
        mx = 0;
        my = my + 1;
        if (my == v_total) begin
          my = 0;
          mf = (mf + 1) % 4096;  // 12 bit frame count
        end
      end
    end
  endtask

  task automatic check_position(input string name, input mode_t m, input bit with_data);
    logic exp_de;
    logic exp_hs;
    logic exp_vs;
    if (!pos_vld) begin
      check_bit(name, "de", 1'b0, hdmi_de);
      check_bit(name, "hs", 1'b0, hdmi_hs);
      check_bit(name, "vs", 1'b0, hdmi_vs);
      check_pix(name, '0, hdmi_data);
    end else begin
      exp_de = (mx < h_active) && (my < v_active);
      exp_hs = (mx >= hs_start) && (mx < hs_end);
      exp_vs = (my >= vs_start) && (my < vs_end);
      check_bit(name, "de", exp_de, hdmi_de);
      check_bit(name, "hs", exp_hs, hdmi_hs);
      check_bit(name, "vs", exp_vs, hdmi_vs);
      if (with_data) begin
        check_pix(name, expected_pix(m, mx, my, mf), hdmi_data);
      end
    end
  endtask

  // starts at the end of the active lines so the new mode lands in blanking
  task automatic run_frame(input string name, input mode_t m);
    int i;
    mode_sw = m;
    for (i = 1; i <= frame_cycles; i++) begin
      advance();
      check_position(name, m, i > settle_cycles);
    end
  endtask

  task automatic test_reset();
    $display("test reset");
    rst = 1'b1;
    repeat (3) begin
      @(negedge sys0_clk);
      check_position("reset", 4'd0, 1'b1);
    end
    rst = 1'b0;
    cyc = 0;
    advance();
    check_position("reset", 4'd0, 1'b1);
  endtask

  task automatic test_sync_timing();
    $display("test sync timing");
    repeat (v_active * h_total) begin  // active lines of the first frame
      advance();
      check_position("sync", 4'd0, 1'b1);
    end
    repeat (2) run_frame("sync", 4'd0);
  endtask

  task automatic test_gradients();
    int m;
    $display("test gradients");
    for (m = 0; m < 8; m++) begin
      run_frame($sformatf("gradient mode %0d", m), mode_t'(m));
    end
  endtask

  task automatic test_box();
    $display("test box overlay");
    run_frame("box", 4'd8);  // box lines 6 to 8 fall in blanking
  endtask

  task automatic test_frame_count();
    $display("test frame count");
    repeat (3) run_frame("frame count", 4'd9);
  endtask

  task automatic test_unused_modes();
    int r;
    int pick;
    int n;
    $display("test unused modes");
    for (n = 0; n < 2; n++) begin
      r    = $random(seed);
      pick = 10 + int'($unsigned(r) % 32'd6);
      run_frame($sformatf("unused mode %0d", pick), mode_t'(pick));
    end
  endtask

  initial begin
    rst     = 1'b1;
    mode_sw = '0;
    errors  = 0;
    cyc     = 0;
    pos_vld = 1'b0;
    mx      = 0;
    my      = 0;
    mf      = 0;
    seed    = 50164;

    test_reset();
    test_sync_timing();
    test_gradients();
    test_box();
    test_frame_count();
    test_unused_modes();

    $display("tb_hdmi_pattern: %0d errors over %0d cycles", errors, cyc);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verilog/hdmi_pattern_top.sv */
//--------------------------------------------------------------------------
// hdmi pattern top: raster timing plus test pattern source for the
// HDMI transmitter, timing set here and passed down
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module hdmi_pattern_top import video_pkg::*; #(
  parameter int h_active = def_h_active,
  parameter int h_total  = def_h_total,
  parameter int hs_start = def_hs_start,
  parameter int hs_end   = def_hs_end,
  parameter int v_active = def_v_active,
  parameter int v_total  = def_v_total,
  parameter int vs_start = def_vs_start,
  parameter int vs_end   = def_vs_end,
  parameter int box_lo   = def_box_lo,
  parameter int box_hi   = def_box_hi
) (
  input  logic      sys0_clk,
  input  logic      rst,

  input  mode_t     mode_sw,    // board switches

  output logic      hdmi_de,
  output logic      hdmi_hs,
  output logic      hdmi_vs,
  output pix_data_t hdmi_data
);

  // raster position from the timing generator
  coord_t hcnt;
  coord_t vcnt;
  coord_t fcnt;
  logic   h_act;
  logic   v_act;
  logic   hsync;
  logic   vsync;

  video_timing_gen #(
    .h_active (h_active),
    .h_total  (h_total),
    .hs_start (hs_start),
    .hs_end   (hs_end),
    .v_active (v_active),
    .v_total  (v_total),
    .vs_start (vs_start),
    .vs_end   (vs_end)
  ) video_timing_gen_inst (
    .sys0_clk (sys0_clk),
    .rst      (rst),
    .hcnt     (hcnt),
    .vcnt     (vcnt),
    .fcnt     (fcnt),
    .h_act    (h_act),
    .v_act    (v_act),
    .hsync    (hsync),
    .vsync    (vsync)
  );

  // two cycles from position to pins
  test_pattern_gen #(
    .box_lo (box_lo),
    .box_hi (box_hi)
  ) test_pattern_gen_inst (
    .sys0_clk  (sys0_clk),
    .rst       (rst),
    .mode_sw   (mode_sw),
    .hcnt      (hcnt),
    .vcnt      (vcnt),
    .fcnt      (fcnt),
    .h_act     (h_act),
    .v_act     (v_act),
    .hsync     (hsync),
    .vsync     (vsync),
    .hdmi_de   (hdmi_de),
    .hdmi_hs   (hdmi_hs),
    .hdmi_vs   (hdmi_vs),
    .hdmi_data (hdmi_data)
  );

endmodule

/* video/test_pattern_gen.sv */
//--------------------------------------------------------------------------
// test pattern generator: samples the mode switches, flags the box and
// picks the pixel word, then registers enable, syncs and data for output
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module test_pattern_gen import video_pkg::*; #(
  parameter int box_lo = def_box_lo,
  parameter int box_hi = def_box_hi
) (
  input  logic      sys0_clk,
  input  logic      rst,

  input  mode_t     mode_sw,   // pattern select switches

  input  coord_t    hcnt,
  input  coord_t    vcnt,
  input  coord_t    fcnt,
  input  logic      h_act,
  input  logic      v_act,
  input  logic      hsync,
  input  logic      vsync,

  output logic      hdmi_de,
  output logic      hdmi_hs,
  output logic      hdmi_vs,
  output pix_data_t hdmi_data
);

  localparam coord_t box_min = coord_t'(box_lo);
  localparam coord_t box_max = coord_t'(box_hi);

  // two sampling flops on the switch inputs
  mode_t  mode_s0;
  mode_t  mode_s1;

  // stage 1, position delayed alongside the box flag
  logic   in_box;
  logic   box_d;
  coord_t hcnt_d;
  coord_t vcnt_d;
  coord_t fcnt_d;
  logic   de_d;
  logic   hs_d;
  logic   vs_d;
  logic   pos_vld;  // stage 1 holds a real raster position

  logic [7:0] luma;
  pix_data_t  pix_nxt;

  always_ff @(posedge sys0_clk) begin
    if (rst) begin
      mode_s0 <= '0;
      mode_s1 <= '0;
    end else begin
      mode_s0 <= mode_sw;
      mode_s1 <= mode_s0;
    end
  end

  // inclusive rectangle, same bounds on both axes
  always_comb begin
    in_box = (hcnt >= box_min) && (hcnt <= box_max) &&
             (vcnt >= box_min) && (vcnt <= box_max);
  end

  always_ff @(posedge sys0_clk) begin
    if (rst) begin
      de_d    <= 1'b0;
      hs_d    <= 1'b0;
      vs_d    <= 1'b0;
      pos_vld <= 1'b0;
    end else begin
      de_d    <= h_act & v_act;
      hs_d    <= hsync;
      vs_d    <= vsync;
      pos_vld <= 1'b1;
    end
  end

  always_ff @(posedge sys0_clk) begin
    box_d  <= in_box;
    hcnt_d <= hcnt;
    vcnt_d <= vcnt;
    fcnt_d <= fcnt;
  end

  // luma select, unused modes fall back to the column ramp
  always_comb begin
    case (mode_s1)
      4'd1:    luma = vcnt_d[7:0];
      4'd2:    luma = hcnt_d[8:1];
      4'd3:    luma = vcnt_d[8:1];
      4'd4:    luma = hcnt_d[9:2];
      4'd5:    luma = vcnt_d[9:2];
      4'd6:    luma = hcnt_d[10:3];
      4'd7:    luma = vcnt_d[10:3];
      4'd8:    luma = box_d ? vcnt_d[7:0] : hcnt_d[7:0];
      4'd9:    luma = box_d ? fcnt_d[7:0] : hcnt_d[7:0];
      default: luma = hcnt_d[7:0];  // mode 0 and 10..15
    endcase
    pix_nxt = {chroma_mid, luma};
  end

  // output flops, data stays zero until the first position arrives
  always_ff @(posedge sys0_clk) begin
    if (rst) begin
      hdmi_de   <= 1'b0;
      hdmi_hs   <= 1'b0;
      hdmi_vs   <= 1'b0;
      hdmi_data <= '0;
    end else begin
      hdmi_de <= de_d;
      hdmi_hs <= hs_d;
      hdmi_vs <= vs_d;
      if (pos_vld) begin
        hdmi_data <= pix_nxt;  // driven in blanking too
      end else begin
        hdmi_data <= '0;
      end
    end
  end

endmodule

/* video/video_timing_gen.sv */
//--------------------------------------------------------------------------
// video timing generator: column, line and frame counters with
// registered active and sync flags aligned to the counter values
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module video_timing_gen import video_pkg::*; #(
  parameter int h_active = def_h_active,
  parameter int h_total  = def_h_total,
  parameter int hs_start = def_hs_start,
  parameter int hs_end   = def_hs_end,
  parameter int v_active = def_v_active,
  parameter int v_total  = def_v_total,
  parameter int vs_start = def_vs_start,
  parameter int vs_end   = def_vs_end
) (
  input  logic   sys0_clk,
  input  logic   rst,

  output coord_t hcnt,   // pixel column
  output coord_t vcnt,   // line number
  output coord_t fcnt,   // frame number, free running
  output logic   h_act,
  output logic   v_act,
  output logic   hsync,
  output logic   vsync
);

  // counter limits and window bounds at counter width
  localparam coord_t h_last    = coord_t'(h_total - 1);
  localparam coord_t v_last    = coord_t'(v_total - 1);
  localparam coord_t h_act_end = coord_t'(h_active);
  localparam coord_t v_act_end = coord_t'(v_active);
  localparam coord_t hs_lo     = coord_t'(hs_start);
  localparam coord_t hs_hi     = coord_t'(hs_end);
  localparam coord_t vs_lo     = coord_t'(vs_start);
  localparam coord_t vs_hi     = coord_t'(vs_end);

  logic   h_wrap;   // last column of a line
  logic   v_wrap;   // last line of a frame
  coord_t hcnt_nxt;
  coord_t vcnt_nxt;
  coord_t fcnt_nxt;

  logic   h_act_nxt;
  logic   v_act_nxt;
  logic   hsync_nxt;
  logic   vsync_nxt;

  // next raster position
  always_comb begin
    h_wrap = (hcnt == h_last);
    v_wrap = (vcnt == v_last);

    if (h_wrap) begin
      hcnt_nxt = '0;
    end else begin
      hcnt_nxt = coord_t'(hcnt + 1'b1);
    end

    vcnt_nxt = vcnt;
    if (h_wrap) begin
      if (v_wrap) begin
        vcnt_nxt = '0;
      end else begin
        vcnt_nxt = coord_t'(vcnt + 1'b1);
      end
    end

    // frame count rolls over on its own at 12 bits
    if (h_wrap && v_wrap) begin
      fcnt_nxt = coord_t'(fcnt + 1'b1);
    end else begin
      fcnt_nxt = fcnt;
    end
  end

  // flags decoded from the next position so they land with the counters
  always_comb begin
    h_act_nxt = (hcnt_nxt < h_act_end);
    v_act_nxt = (vcnt_nxt < v_act_end);
    hsync_nxt = (hcnt_nxt >= hs_lo) && (hcnt_nxt < hs_hi);
    vsync_nxt = (vcnt_nxt >= vs_lo) && (vcnt_nxt < vs_hi);
  end

  always_ff @(posedge sys0_clk) begin
    if (rst) begin
      hcnt <= '0;
      vcnt <= '0;
      fcnt <= '0;
    end else begin
      hcnt <= hcnt_nxt;
      vcnt <= vcnt_nxt;
      fcnt <= fcnt_nxt;
    end
  end

  // during reset the flags already describe the origin (0, 0)
  always_ff @(posedge sys0_clk) begin
    if (rst) begin
      h_act <= 1'b1;  // column 0 is active
      v_act <= 1'b1;  // line 0 is active
      hsync <= 1'b0;
      vsync <= 1'b0;
    end else begin
      h_act <= h_act_nxt;
      v_act <= v_act_nxt;
      hsync <= hsync_nxt;
      vsync <= vsync_nxt;
    end
  end

endmodule

/* common/video_pkg.sv */
//--------------------------------------------------------------------------
// video package: raster types and default 1080p60 timing constants
// shared by the timing generator, the pattern generator and the top level
//--------------------------------------------------------------------------

package video_pkg;

  localparam int coord_w = 12;  // enough for 2200 columns / 1125 lines
  localparam int pix_w   = 16;  // chroma byte over luma byte
  localparam int mode_w  = 4;

  typedef logic [coord_w-1:0] coord_t;     // column, line or frame number
  typedef logic [pix_w-1:0]   pix_data_t;  // {chroma, luma}
  typedef logic [mode_w-1:0]  mode_t;      // pattern select

  // fixed chroma, grey
  localparam logic [7:0] chroma_mid = 8'h80;

  // horizontal timing, in pixel clocks
  localparam int def_h_active = 1920;
  localparam int def_h_total  = 2200;
  localparam int def_hs_start = 2008;  // front porch 88
  localparam int def_hs_end   = 2052;  // sync width 44

  // vertical timing, in lines
  localparam int def_v_active = 1080;
  localparam int def_v_total  = 1125;
  localparam int def_vs_start = 1084;  // front porch 4
  localparam int def_vs_end   = 1089;  // sync width 5

  // inclusive box bounds, same on both axes
  localparam int def_box_lo = 128;
  localparam int def_box_hi = 255;

endpackage
